// File: hdl/exu_pkg.sv
/*
  Shared widths and encodings for the integer execution stage.
  Imported by the RTL blocks that need data widths or operation codes.
*/
`default_nettype none

package exu_pkg;

  //////////////////////////////
  // Widths
  localparam int XLEN    = 32;  // Data and address width
  localparam int RFIDX_W = 5;   // Register index
  localparam int INSTR_W = 32;

  //////////////////////////////
  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // Register-register ALU
    OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011
  } major_op_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10   // Operand b straight through, for LUI
  } alu_op_e;

endpackage

`default_nettype wire

// File: hdl/exu_regfile.sv
/*
  Integer register file, 32 entries with x0 fixed at zero.
  Two combinational read ports and one write port that lands at the clock edge.
*/
`default_nettype none

module exu_regfile import exu_pkg::*; (
  input  wire                clk,
  input  wire                i_rst,
  input  wire  [RFIDX_W-1:0] i_rs1idx,
  input  wire  [RFIDX_W-1:0] i_rs2idx,
  output logic [XLEN-1:0]    o_rs1_data,
  output logic [XLEN-1:0]    o_rs2_data,
  input  wire                i_wen,
  input  wire  [RFIDX_W-1:0] i_wrdidx,
  input  wire  [XLEN-1:0]    i_wdata
);

  logic [XLEN-1:0] regs [1:31];  // No storage behind x0

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_wrdidx != '0)) begin
      regs[i_wrdidx] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1idx == '0) ? '0 : regs[i_rs1idx];
  assign o_rs2_data = (i_rs2idx == '0) ? '0 : regs[i_rs2idx];

  // Decode must have cleared rdwen for x0 on both the ALU and the load path
  a_no_x0_write: assert property (@(posedge clk) disable iff (i_rst)
    i_wen |-> (i_wrdidx != '0));

endmodule

`default_nettype wire

// File: hdl/exu_decode.sv
/*
  Instruction decode for the reduced RV32I set: OP, OP-IMM, LUI and LW.
  Purely combinational. Unknown opcodes come out with every enable low,
  so they pass through dispatch without touching any state.
*/
`default_nettype none

module exu_decode import exu_pkg::*; (
  input  wire  [INSTR_W-1:0] i_instr,
  output logic [RFIDX_W-1:0] o_rs1idx,
  output logic [RFIDX_W-1:0] o_rs2idx,
  output logic [RFIDX_W-1:0] o_rdidx,
  output logic               o_rs1en,
  output logic               o_rs2en,
  output logic               o_rdwen,
  output alu_op_e            o_alu_op,
  output logic [XLEN-1:0]    o_imm,
  output logic               o_use_imm,
  output logic               o_is_load
);

  major_op_e       opcode;
  logic [2:0]      funct3;
  logic            funct7_b5;  // SUB and SRA select
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic            rd_write;   // Format writes rd, before the x0 check

  assign opcode    = major_op_e'(i_instr[6:0]);
  assign funct3    = i_instr[14:12];
  assign funct7_b5 = i_instr[30];

  assign o_rdidx  = i_instr[11:7];
  assign o_rs1idx = i_instr[19:15];
  assign o_rs2idx = i_instr[24:20];

  assign imm_i = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_u = {i_instr[31:12], 12'b0};

  always_comb begin
    o_rs1en   = 1'b0;
    o_rs2en   = 1'b0;
    rd_write  = 1'b0;
    o_alu_op  = ALU_ADD;
    o_imm     = imm_i;
    o_use_imm = 1'b0;
    o_is_load = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        o_rs1en   = 1'b1;
        o_rs2en   = (opcode == OPC_OP);
        rd_write  = 1'b1;
        o_use_imm = (opcode == OPC_OP_IMM);
        case (funct3)
          3'b000:  o_alu_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
          3'b001:  o_alu_op = ALU_SLL;
          3'b010:  o_alu_op = ALU_SLT;
          3'b011:  o_alu_op = ALU_SLTU;
          3'b100:  o_alu_op = ALU_XOR;
          3'b101:  o_alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110:  o_alu_op = ALU_OR;
          default: o_alu_op = ALU_AND;
        endcase
      end
      OPC_LUI: begin
        rd_write  = 1'b1;
        o_alu_op  = ALU_PASS_B;
        o_imm     = imm_u;
        o_use_imm = 1'b1;
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin  // LW only
          o_rs1en   = 1'b1;
          rd_write  = 1'b1;
          o_use_imm = 1'b1;
          o_is_load = 1'b1;
        end
      end
      default: ;  // Accepted, then dropped
    endcase
  end

  assign o_rdwen = rd_write & (o_rdidx != '0);

endmodule

`default_nettype wire

// File: hdl/exu_disp.sv
/*
  Dispatch. Holds the instruction on a hazard against outstanding loads and
  sends it either to the ALU or, as a load command, to the load unit.
  Combinational. o_ready does not depend on i_valid.
*/
`default_nettype none

module exu_disp import exu_pkg::*; #(
  parameter int PTR_W = 1
) (
  input  wire              i_valid,
  output logic             o_ready,
  input  wire              i_rs1en,
  input  wire              i_rs2en,
  input  wire              i_rdwen,
  input  alu_op_e          i_alu_op,
  input  wire  [XLEN-1:0]  i_imm,
  input  wire              i_use_imm,
  input  wire              i_is_load,
  input  wire  [XLEN-1:0]  i_rs1_data,
  input  wire  [XLEN-1:0]  i_rs2_data,
  input  wire              i_oitf_full,
  input  wire  [PTR_W-1:0] i_oitf_ptr,
  input  wire              i_match_rs1,
  input  wire              i_match_rs2,
  input  wire              i_match_rd,
  input  wire              i_alu_wbck_ready,
  output logic [XLEN-1:0]  o_alu_a,
  output logic [XLEN-1:0]  o_alu_b,
  output alu_op_e          o_alu_op,
  output logic             o_alu_valid,
  output logic             o_oitf_ena,
  output logic             o_lsu_cmd_valid,
  input  wire              i_lsu_cmd_ready,
  output logic [PTR_W-1:0] o_lsu_cmd_itag
);

  logic hazard;

  // RAW on either source, or WAW on rd, against a load still in flight
  assign hazard = (i_rs1en & i_match_rs1)
                | (i_rs2en & i_match_rs2)
                | (i_rdwen & i_match_rd);

  assign o_ready = ~hazard & (i_is_load ? (~i_oitf_full & i_lsu_cmd_ready)
                                        : i_alu_wbck_ready);

  //////////////////////////////
  // Operands
  assign o_alu_a  = i_rs1_data;
  assign o_alu_b  = i_use_imm ? i_imm : i_rs2_data;
  assign o_alu_op = i_is_load ? ALU_ADD : i_alu_op;  // Address add for LW

  //////////////////////////////
  // Routing
  assign o_alu_valid     = i_valid & ~i_is_load & ~hazard;
  assign o_lsu_cmd_valid = i_valid & i_is_load & ~hazard & ~i_oitf_full;
  assign o_lsu_cmd_itag  = i_oitf_ptr;
  assign o_oitf_ena      = o_lsu_cmd_valid & i_lsu_cmd_ready;

endmodule

`default_nettype wire

// File: hdl/exu_oitf.sv
/*
  Outstanding instruction FIFO for loads in flight.
  One entry is allocated when a load command is taken and the oldest
  is retired when its response is written back. Match flags feed the
  dispatch hazard check.
*/
`default_nettype none

module exu_oitf import exu_pkg::*; #(
  parameter int OITF_DEPTH = 2,
  localparam int PTR_W = (OITF_DEPTH > 1) ? $clog2(OITF_DEPTH) : 1
) (
  input  wire                clk,
  input  wire                i_rst,
  input  wire                i_dis_ena,
  input  wire                i_dis_rdwen,
  input  wire  [RFIDX_W-1:0] i_dis_rdidx,
  input  wire  [RFIDX_W-1:0] i_rs1idx,
  input  wire  [RFIDX_W-1:0] i_rs2idx,
  output logic [PTR_W-1:0]   o_dis_ptr,
  output logic               o_full,
  output logic               o_empty,
  input  wire                i_ret_ena,
  output logic [PTR_W-1:0]   o_ret_ptr,
  output logic [RFIDX_W-1:0] o_ret_rdidx,
  output logic               o_ret_rdwen,
  output logic               o_match_rs1,
  output logic               o_match_rs2,
  output logic               o_match_rd
);

  localparam logic [PTR_W-1:0] LAST = PTR_W'(OITF_DEPTH - 1);

  logic [PTR_W-1:0]   alc_ptr;
  logic [PTR_W-1:0]   ret_ptr;
  logic               alc_wrap;
  logic               ret_wrap;
  logic [OITF_DEPTH-1:0] vld;
  logic [OITF_DEPTH-1:0] rdwen_q;
  logic [RFIDX_W-1:0] rdidx_q [OITF_DEPTH];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      alc_ptr  <= '0;
      alc_wrap <= 1'b0;
      ret_ptr  <= '0;
      ret_wrap <= 1'b0;
      vld      <= '0;
    end else begin
      if (i_dis_ena) begin
        vld[alc_ptr] <= 1'b1;
        alc_ptr      <= (alc_ptr == LAST) ? '0 : alc_ptr + 1'b1;
        alc_wrap     <= alc_wrap ^ (alc_ptr == LAST);
      end
      if (i_ret_ena) begin
        vld[ret_ptr] <= 1'b0;  // Never the entry being allocated
        ret_ptr      <= (ret_ptr == LAST) ? '0 : ret_ptr + 1'b1;
        ret_wrap     <= ret_wrap ^ (ret_ptr == LAST);
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (i_dis_ena) begin
      rdidx_q[alc_ptr] <= i_dis_rdidx;
      rdwen_q[alc_ptr] <= i_dis_rdwen;
    end
  end

  assign o_empty   = (alc_ptr == ret_ptr) & (alc_wrap == ret_wrap);
  assign o_full    = (alc_ptr == ret_ptr) & (alc_wrap != ret_wrap);
  assign o_dis_ptr = alc_ptr;
  assign o_ret_ptr = ret_ptr;

  assign o_ret_rdidx = rdidx_q[ret_ptr];
  assign o_ret_rdwen = rdwen_q[ret_ptr];

  always_comb begin
    o_match_rs1 = 1'b0;
    o_match_rs2 = 1'b0;
    o_match_rd  = 1'b0;
    for (int i = 0; i < OITF_DEPTH; i++) begin
      if (vld[i] && rdwen_q[i]) begin
        o_match_rs1 |= (rdidx_q[i] == i_rs1idx);
        o_match_rs2 |= (rdidx_q[i] == i_rs2idx);
        o_match_rd  |= (rdidx_q[i] == i_dis_rdidx);
      end
    end
  end

  // Dispatch and the load unit together must respect the FIFO bounds
  a_no_alloc_full: assert property (@(posedge clk) disable iff (i_rst)
    i_dis_ena |-> !o_full);
  a_no_ret_empty: assert property (@(posedge clk) disable iff (i_rst)
    i_ret_ena |-> !o_empty);

endmodule

`default_nettype wire

// File: hdl/exu_alu.sv
/*
  Single-cycle integer ALU. Also computes the load address,
  dispatch selects ADD with the I-type immediate for LW.
*/
`default_nettype none

module exu_alu import exu_pkg::*; (
  input  wire  [XLEN-1:0] i_a,
  input  wire  [XLEN-1:0] i_b,
  input  alu_op_e         i_op,
  output logic [XLEN-1:0] o_result
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_AND:    o_result = i_a & i_b;
      ALU_OR:     o_result = i_a | i_b;
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_SLT:    o_result = XLEN'($signed(i_a) < $signed(i_b));
      ALU_SLTU:   o_result = XLEN'(i_a < i_b);
      ALU_SLL:    o_result = i_a << shamt;
      ALU_SRL:    o_result = i_a >> shamt;
      ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);
      ALU_PASS_B: o_result = i_b;
      default:    o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/exu_wbck.sv
/*
  Final write-back arbiter for the register file write port.
  A load response always wins and retires the OITF head; ALU results
  take the port in every other cycle.
*/
`default_nettype none

module exu_wbck import exu_pkg::*; #(
  parameter int OITF_DEPTH = 2,
  localparam int PTR_W = (OITF_DEPTH > 1) ? $clog2(OITF_DEPTH) : 1
) (
  input  wire                i_lsu_rsp_valid,
  input  wire  [XLEN-1:0]    i_lsu_rsp_data,
  input  wire  [PTR_W-1:0]   i_lsu_rsp_itag,
  input  wire  [PTR_W-1:0]   i_ret_ptr,
  input  wire  [RFIDX_W-1:0] i_ret_rdidx,
  input  wire                i_ret_rdwen,
  input  wire                i_oitf_empty,
  output logic               o_ret_ena,
  input  wire                i_alu_valid,
  input  wire  [RFIDX_W-1:0] i_alu_rdidx,
  input  wire                i_alu_rdwen,
  input  wire  [XLEN-1:0]    i_alu_data,
  output logic               o_alu_ready,
  output logic               o_wen,
  output logic [RFIDX_W-1:0] o_wrdidx,
  output logic [XLEN-1:0]    o_wdata
);

  assign o_ret_ena   = i_lsu_rsp_valid;
  assign o_alu_ready = ~i_lsu_rsp_valid;

  assign o_wen    = i_lsu_rsp_valid ? i_ret_rdwen : (i_alu_valid & i_alu_rdwen);
  assign o_wrdidx = i_lsu_rsp_valid ? i_ret_rdidx : i_alu_rdidx;
  assign o_wdata  = i_lsu_rsp_valid ? i_lsu_rsp_data : i_alu_data;

  // Load unit returns in command order, only for loads in flight
  always_comb begin
    a_rsp_outstanding: assert final (!i_lsu_rsp_valid || !i_oitf_empty)
      else $error("load response with no load outstanding");
    a_rsp_in_order: assert final (!i_lsu_rsp_valid || (i_lsu_rsp_itag == i_ret_ptr))
      else $error("load response itag is not the OITF head");
  end

endmodule

`default_nettype wire

// File: hdl/exu_top.sv
/*
  Integer execution stage top level. Connects decode, register file,
  dispatch, OITF, ALU and final write-back. OITF_DEPTH sets how many
  loads may be in flight at once.
*/
`default_nettype none

module exu_top import exu_pkg::*; #(
  parameter int OITF_DEPTH = 2,
  localparam int PTR_W = (OITF_DEPTH > 1) ? $clog2(OITF_DEPTH) : 1
) (
  input  wire                clk,
  input  wire                i_rst,
  input  wire                i_valid,
  output logic               o_ready,
  input  wire  [INSTR_W-1:0] i_instr,
  output logic               o_lsu_cmd_valid,
  input  wire                i_lsu_cmd_ready,
  output logic [XLEN-1:0]    o_lsu_cmd_addr,
  output logic [PTR_W-1:0]   o_lsu_cmd_itag,
  input  wire                i_lsu_rsp_valid,
  input  wire  [XLEN-1:0]    i_lsu_rsp_data,
  input  wire  [PTR_W-1:0]   i_lsu_rsp_itag,
  output logic               o_wbck_valid,
  output logic [RFIDX_W-1:0] o_wbck_rdidx,
  output logic [XLEN-1:0]    o_wbck_wdata,
  output logic               o_exu_active
);

  //////////////////////////////
  // Decode
  logic [RFIDX_W-1:0] dec_rs1idx;
  logic [RFIDX_W-1:0] dec_rs2idx;
  logic [RFIDX_W-1:0] dec_rdidx;
  logic               dec_rs1en;
  logic               dec_rs2en;
  logic               dec_rdwen;
  alu_op_e            dec_alu_op;
  logic [XLEN-1:0]    dec_imm;
  logic               dec_use_imm;
  logic               dec_is_load;

  exu_decode u_exu_decode (
    .i_instr   (i_instr),
    .o_rs1idx  (dec_rs1idx),
    .o_rs2idx  (dec_rs2idx),
    .o_rdidx   (dec_rdidx),
    .o_rs1en   (dec_rs1en),
    .o_rs2en   (dec_rs2en),
    .o_rdwen   (dec_rdwen),
    .o_alu_op  (dec_alu_op),
    .o_imm     (dec_imm),
    .o_use_imm (dec_use_imm),
    .o_is_load (dec_is_load)
  );

  //////////////////////////////
  // Register file
  logic [XLEN-1:0] rf_rs1;
  logic [XLEN-1:0] rf_rs2;

  exu_regfile u_exu_regfile (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_rs1idx   (dec_rs1idx),
    .i_rs2idx   (dec_rs2idx),
    .o_rs1_data (rf_rs1),
    .o_rs2_data (rf_rs2),
    .i_wen      (o_wbck_valid),    // Write port is also the observation port
    .i_wrdidx   (o_wbck_rdidx),
    .i_wdata    (o_wbck_wdata)
  );

  //////////////////////////////
  // Dispatch and ALU
  logic [XLEN-1:0]  alu_a;
  logic [XLEN-1:0]  alu_b;
  alu_op_e          alu_op;
  logic             alu_valid;
  logic             alu_wbck_ready;
  logic [XLEN-1:0]  alu_result;
  logic             oitf_ena;
  logic             oitf_full;
  logic             oitf_empty;
  logic [PTR_W-1:0] oitf_dis_ptr;
  logic             match_rs1;
  logic             match_rs2;
  logic             match_rd;

  exu_disp #(.PTR_W(PTR_W)) u_exu_disp (
    .i_valid          (i_valid),
    .o_ready          (o_ready),
    .i_rs1en          (dec_rs1en),
    .i_rs2en          (dec_rs2en),
    .i_rdwen          (dec_rdwen),
    .i_alu_op         (dec_alu_op),
    .i_imm            (dec_imm),
    .i_use_imm        (dec_use_imm),
    .i_is_load        (dec_is_load),
    .i_rs1_data       (rf_rs1),
    .i_rs2_data       (rf_rs2),
    .i_oitf_full      (oitf_full),
    .i_oitf_ptr       (oitf_dis_ptr),
    .i_match_rs1      (match_rs1),
    .i_match_rs2      (match_rs2),
    .i_match_rd       (match_rd),
    .i_alu_wbck_ready (alu_wbck_ready),
    .o_alu_a          (alu_a),
    .o_alu_b          (alu_b),
    .o_alu_op         (alu_op),
    .o_alu_valid      (alu_valid),
    .o_oitf_ena       (oitf_ena),
    .o_lsu_cmd_valid  (o_lsu_cmd_valid),
    .i_lsu_cmd_ready  (i_lsu_cmd_ready),
    .o_lsu_cmd_itag   (o_lsu_cmd_itag)
  );

  exu_alu u_exu_alu (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_op     (alu_op),
    .o_result (alu_result)
  );

  assign o_lsu_cmd_addr = alu_result;  // rs1 + imm for a load

  //////////////////////////////
  // OITF and write-back
  logic               oitf_ret_ena;
  logic [PTR_W-1:0]   oitf_ret_ptr;
  logic [RFIDX_W-1:0] oitf_ret_rdidx;
  logic               oitf_ret_rdwen;

  exu_oitf #(.OITF_DEPTH(OITF_DEPTH)) u_exu_oitf (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_dis_ena   (oitf_ena),
    .i_dis_rdwen (dec_rdwen),
    .i_dis_rdidx (dec_rdidx),
    .i_rs1idx    (dec_rs1idx),
    .i_rs2idx    (dec_rs2idx),
    .o_dis_ptr   (oitf_dis_ptr),
    .o_full      (oitf_full),
    .o_empty     (oitf_empty),
    .i_ret_ena   (oitf_ret_ena),
    .o_ret_ptr   (oitf_ret_ptr),
    .o_ret_rdidx (oitf_ret_rdidx),
    .o_ret_rdwen (oitf_ret_rdwen),
    .o_match_rs1 (match_rs1),
    .o_match_rs2 (match_rs2),
    .o_match_rd  (match_rd)
  );

  exu_wbck #(.OITF_DEPTH(OITF_DEPTH)) u_exu_wbck (
    .i_lsu_rsp_valid (i_lsu_rsp_valid),
    .i_lsu_rsp_data  (i_lsu_rsp_data),
    .i_lsu_rsp_itag  (i_lsu_rsp_itag),
    .i_ret_ptr       (oitf_ret_ptr),
    .i_ret_rdidx     (oitf_ret_rdidx),
    .i_ret_rdwen     (oitf_ret_rdwen),
    .i_oitf_empty    (oitf_empty),
    .o_ret_ena       (oitf_ret_ena),
    .i_alu_valid     (alu_valid),
    .i_alu_rdidx     (dec_rdidx),
    .i_alu_rdwen     (dec_rdwen),
    .i_alu_data      (alu_result),
    .o_alu_ready     (alu_wbck_ready),
    .o_wen           (o_wbck_valid),
    .o_wrdidx        (o_wbck_rdidx),
    .o_wdata         (o_wbck_wdata)
  );

  assign o_exu_active = ~oitf_empty | i_valid;

endmodule

`default_nettype wire

// File: verif/exu_tb.sv
/*
  Random-program testbench for the integer execution stage.
  A reference model runs every accepted instruction in program order and
  a load-unit model answers load commands in order after random delays.
*/
`default_nettype none

module exu_tb import exu_pkg::*; ();

  localparam int OITF_DEPTH     = 2;
  localparam int PTR_W          = 1;
  localparam int NUM_INSTR      = 400;
  localparam int ACCEPT_TIMEOUT = 200;  // Cycles one instruction may wait
  localparam int DRAIN_TIMEOUT  = 500;

  logic               clk = 1'b0;
  logic               i_rst;
  logic               i_valid;
  logic               o_ready;
  logic [INSTR_W-1:0] i_instr;
  logic               o_lsu_cmd_valid;
  logic               i_lsu_cmd_ready = 1'b0;
  logic [XLEN-1:0]    o_lsu_cmd_addr;
  logic [PTR_W-1:0]   o_lsu_cmd_itag;
  logic               i_lsu_rsp_valid = 1'b0;
  logic [XLEN-1:0]    i_lsu_rsp_data  = '0;
  logic [PTR_W-1:0]   i_lsu_rsp_itag  = '0;
  logic               o_wbck_valid;
  logic [RFIDX_W-1:0] o_wbck_rdidx;
  logic [XLEN-1:0]    o_wbck_wdata;
  logic               o_exu_active;

  integer             seed;
  int                 accept_cnt = 0;
  int                 load_cnt   = 0;
  logic [XLEN-1:0]    mregs [32];       // Model registers, x0 never written
  logic [XLEN-1:0]    lsu_mem [256];
  logic [INSTR_W-1:0] prog [NUM_INSTR];
  int                 gap [NUM_INSTR];  // Idle cycles before each instruction

  // Expected register writes
  logic [RFIDX_W-1:0] alu_rd_q[$];
  logic [XLEN-1:0]    alu_data_q[$];
  logic [RFIDX_W-1:0] ld_rd_q[$];       // Doubles as the list of loads in flight
  logic               ld_wen_q[$];
  logic [XLEN-1:0]    ld_data_q[$];

  // Commands held by the load unit
  logic [XLEN-1:0]    lsu_addr_q[$];
  logic [PTR_W-1:0]   lsu_itag_q[$];

  exu_top #(.OITF_DEPTH(OITF_DEPTH)) u_exu_top (
    .clk             (clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .o_ready         (o_ready),
    .i_instr         (i_instr),
    .o_lsu_cmd_valid (o_lsu_cmd_valid),
    .i_lsu_cmd_ready (i_lsu_cmd_ready),
    .o_lsu_cmd_addr  (o_lsu_cmd_addr),
    .o_lsu_cmd_itag  (o_lsu_cmd_itag),
    .i_lsu_rsp_valid (i_lsu_rsp_valid),
    .i_lsu_rsp_data  (i_lsu_rsp_data),
    .i_lsu_rsp_itag  (i_lsu_rsp_itag),
    .o_wbck_valid    (o_wbck_valid),
    .o_wbck_rdidx    (o_wbck_rdidx),
    .o_wbck_wdata    (o_wbck_wdata),
    .o_exu_active    (o_exu_active)
  );

  always #50 clk = ~clk;

  task automatic check_val(input string what, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error at time %0t: %s", $time, why);
    $display("Test failed");
    $fatal(1);
  endtask

  // Load data depends on every address bit
  function automatic logic [XLEN-1:0] load_word(input logic [XLEN-1:0] addr);
    return lsu_mem[addr[7:0]] ^ addr;
  endfunction

  //////////////////////////////
  // Random program
  task automatic make_instr(output logic [INSTR_W-1:0] ins);
    int                 sel;
    logic [RFIDX_W-1:0] rd;
    logic [RFIDX_W-1:0] rs1;
    logic [RFIDX_W-1:0] rs2;
    logic [2:0]         f3;
    logic [11:0]        imm;
    logic [6:0]         f7;
    sel = $random(seed) & 15;
    rd  = 5'($random(seed) & 7);  // x0 to x7 keeps hazards frequent
    rs1 = 5'($random(seed) & 7);
    rs2 = 5'($random(seed) & 7);
    f3  = 3'($random(seed));
    imm = 12'($random(seed));
    f7  = ($random(seed) & 1) ? 7'h20 : 7'h00;
    if (sel < 5) begin
      if (f3 != 3'd0 && f3 != 3'd5) f7 = 7'h00;
      ins = {f7, rs2, rs1, f3, rd, 7'h33};
    end else if (sel < 9 || sel == 15) begin
      if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
      else if (f3 == 3'd5) imm = {f7, imm[4:0]};
      ins = {imm, rs1, f3, rd, 7'h13};
    end else if (sel == 9) begin
      ins = {20'($random(seed)), rd, 7'h37};
    end else if (sel < 14) begin
      ins = {imm, rs1, 3'b010, rd, 7'h03};  // LW
    end else begin
      ins = {25'($random(seed)), 7'h0f};    // Not decoded here
    end
  endtask

  //////////////////////////////
  // Reference model
  // kind: 0 dropped, 1 ALU, 2 load; val is the result or the load address
  task automatic model_decode(input logic [INSTR_W-1:0] ins, output int kind,
                              output logic use1, output logic use2,
                              output logic [RFIDX_W-1:0] rd, output logic [XLEN-1:0] val);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_i;
    opc   = ins[6:0];
    f3    = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    a     = mregs[ins[19:15]];
    b     = (opc == 7'h33) ? mregs[ins[24:20]] : imm_i;
    kind  = 0;
    use1  = 1'b0;
    use2  = 1'b0;
    rd    = ins[11:7];
    val   = '0;
    if (opc == 7'h33 || opc == 7'h13) begin
      kind = 1;
      use1 = 1'b1;
      use2 = (opc == 7'h33);
      case (f3)
        3'd0:    val = (opc == 7'h33 && ins[30]) ? a - b : a + b;
        3'd1:    val = a << b[4:0];
        3'd2:    val = {31'b0, $signed(a) < $signed(b)};
        3'd3:    val = {31'b0, a < b};
        3'd4:    val = a ^ b;
        3'd5:    val = ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    val = a | b;
        default: val = a & b;
      endcase
    end else if (opc == 7'h37) begin
      kind = 1;
      val  = {ins[31:12], 12'b0};
    end else if (opc == 7'h03 && f3 == 3'b010) begin
      kind = 2;
      use1 = 1'b1;
      val  = a + imm_i;
    end
  endtask

  // Runs mid-cycle, once all DUT outputs have settled
  task automatic check_cycle();
    int                 kind;
    logic               use1;
    logic               use2;
    logic               wen;
    logic               hazard;
    logic               exp_ready;
    logic [RFIDX_W-1:0] rd;
    logic [XLEN-1:0]    val;
    logic [XLEN-1:0]    data;
    check_val("o_exu_active", o_exu_active, (ld_rd_q.size() > 0) || i_valid);
    if (i_valid) begin
      model_decode(i_instr, kind, use1, use2, rd, val);
      wen    = (kind != 0) && (rd != '0);
      hazard = 1'b0;
      foreach (ld_rd_q[k]) begin
        if (ld_wen_q[k]) begin
          hazard |= use1 && (ld_rd_q[k] == i_instr[19:15]);
          hazard |= use2 && (ld_rd_q[k] == i_instr[24:20]);
          hazard |= wen && (ld_rd_q[k] == rd);
        end
      end
      if (kind == 2) exp_ready = !hazard && (ld_rd_q.size() < OITF_DEPTH) && i_lsu_cmd_ready;
      else exp_ready = !hazard && !i_lsu_rsp_valid;
      check_val("o_ready", o_ready, exp_ready);
      if (kind != 2) check_val("o_lsu_cmd_valid for a non-load", o_lsu_cmd_valid, 1'b0);
      // A command is taken only together with the accept of its load
      check_val("load command handshake", o_lsu_cmd_valid && i_lsu_cmd_ready,
                o_ready && (kind == 2));
      if (o_ready) begin
        accept_cnt++;
        if (kind == 1 && wen) begin
          mregs[rd] = val;
          alu_rd_q.push_back(rd);
          alu_data_q.push_back(val);
        end
        if (kind == 2) begin
          data = load_word(val);
          check_val("o_lsu_cmd_valid", o_lsu_cmd_valid, 1'b1);
          check_val("o_lsu_cmd_addr", o_lsu_cmd_addr, val);
          check_val("o_lsu_cmd_itag", o_lsu_cmd_itag, load_cnt % OITF_DEPTH);
          load_cnt++;
          if (wen) mregs[rd] = data;
          ld_rd_q.push_back(rd);
          ld_wen_q.push_back(wen);
          ld_data_q.push_back(data);
          lsu_addr_q.push_back(o_lsu_cmd_addr);
          lsu_itag_q.push_back(o_lsu_cmd_itag);
        end
      end
    end else begin
      check_val("o_lsu_cmd_valid while idle", o_lsu_cmd_valid, 1'b0);
    end

    // Write port
    if (o_wbck_valid) check_val("write to x0", o_wbck_rdidx != '0, 1'b1);
    if (i_lsu_rsp_valid) begin
      if (ld_rd_q.size() == 0) begin
        abort_run("load response driven with no load in flight");
      end else begin
        check_val("load o_wbck_valid", o_wbck_valid, ld_wen_q[0]);
        if (ld_wen_q[0]) begin
          check_val("load o_wbck_rdidx", o_wbck_rdidx, ld_rd_q[0]);
          check_val("load o_wbck_wdata", o_wbck_wdata, ld_data_q[0]);
        end
        void'(ld_rd_q.pop_front());
        void'(ld_wen_q.pop_front());
        void'(ld_data_q.pop_front());
      end
    end else if (alu_rd_q.size() > 0) begin
      check_val("ALU o_wbck_valid", o_wbck_valid, 1'b1);
      check_val("ALU o_wbck_rdidx", o_wbck_rdidx, alu_rd_q.pop_front());
      check_val("ALU o_wbck_wdata", o_wbck_wdata, alu_data_q.pop_front());
    end else begin
      check_val("o_wbck_valid with no write due", o_wbck_valid, 1'b0);
    end
  endtask

  always @(negedge clk) begin
    if (!i_rst) check_cycle();
  end

  //////////////////////////////
  // Load unit, answers in command order
  always @(posedge clk) begin
    if (i_rst) begin
      i_lsu_cmd_ready <= 1'b0;
      i_lsu_rsp_valid <= 1'b0;
    end else begin
      i_lsu_cmd_ready <= ($random(seed) & 3) != 0;
      if (lsu_addr_q.size() > 0 && ($random(seed) & 3) == 0) begin
        i_lsu_rsp_valid <= 1'b1;
        i_lsu_rsp_data  <= load_word(lsu_addr_q.pop_front());
        i_lsu_rsp_itag  <= lsu_itag_q.pop_front();
      end else begin
        i_lsu_rsp_valid <= 1'b0;
      end
    end
  end

  // Called at a rising edge; returns at the edge after the accept
  task automatic issue_instr(input logic [INSTR_W-1:0] ins);
    int target;
    int waited;
    target  = accept_cnt + 1;
    waited  = 0;
    i_valid <= 1'b1;
    i_instr <= ins;
    do begin
      @(posedge clk);
      waited++;
      if (waited > ACCEPT_TIMEOUT) abort_run("instruction not accepted before the timeout");
    end while (accept_cnt != target);
  endtask

  task automatic drain_loads();
    int waited;
    waited = 0;
    while (ld_rd_q.size() > 0) begin
      @(posedge clk);
      waited++;
      if (waited > DRAIN_TIMEOUT) abort_run("loads still in flight after the drain timeout");
    end
  endtask

  initial begin
    seed = 22858;
    i_rst   <= 1'b1;
    i_valid <= 1'b0;
    i_instr <= '0;
    for (int i = 0; i < 32; i++) mregs[i] = '0;
    for (int i = 0; i < 256; i++) lsu_mem[i] = $random(seed);
    for (int n = 0; n < NUM_INSTR; n++) begin
      make_instr(prog[n]);
      gap[n] = (($random(seed) & 7) == 0) ? 1 + ($random(seed) & 3) : 0;
    end
    for (int c = 0; c < 16; c++) @(posedge clk);
    i_rst <= 1'b0;

    for (int n = 0; n < NUM_INSTR; n++) begin
      for (int g = 0; g < gap[n]; g++) begin
        i_valid <= 1'b0;
        @(posedge clk);
      end
      issue_instr(prog[n]);
    end
    i_valid <= 1'b0;
    drain_loads();
    @(posedge clk);  // Let the monitor see the idle stage
    @(posedge clk);
    check_val("ALU writes left over", alu_rd_q.size(), '0);
    check_val("load commands left over", lsu_addr_q.size(), '0);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hdl/exu_pkg.sv
hdl/exu_regfile.sv
hdl/exu_decode.sv
hdl/exu_disp.sv
hdl/exu_oitf.sv
hdl/exu_alu.sv
hdl/exu_wbck.sv
hdl/exu_top.sv
verif/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - hdl/exu_pkg.sv
  - hdl/exu_regfile.sv
  - hdl/exu_decode.sv
  - hdl/exu_disp.sv
  - hdl/exu_oitf.sv
  - hdl/exu_alu.sv
  - hdl/exu_wbck.sv
  - hdl/exu_top.sv
  - target: test
    files:
      - verif/exu_tb.sv
